/* design/rv_exec_pkg.sv */
// execute-stage opcodes, instruction class bits and datapath widths; import into stage modules
package rv_exec_pkg;

    localparam int XLEN       = 64;
    localparam int REG_ADDR_W = 5;
    localparam int ITYPE_W    = 8;
    localparam int LS_SEL_W   = 3;

    // bit positions inside inst_type
    localparam int ITYPE_STORE_BIT  = 0;
    localparam int ITYPE_LOAD_BIT   = 1;
    localparam int ITYPE_BRANCH_BIT = 2;
    localparam int ITYPE_CSR_BIT    = 7;

    typedef enum logic [7:0] {
        OP_NOP    = 8'h00,
        OP_ADD    = 8'h01, OP_ADDI  = 8'h02, OP_SUB    = 8'h03, OP_SLT    = 8'h04,
        OP_SLTI   = 8'h05, OP_SLTU  = 8'h06, OP_SLTIU  = 8'h07, OP_XOR    = 8'h08,
        OP_XORI   = 8'h09, OP_OR    = 8'h0a, OP_ORI    = 8'h0b, OP_AND    = 8'h0c,
        OP_ANDI   = 8'h0d, OP_SLL   = 8'h0e, OP_SLLI   = 8'h0f, OP_SRL    = 8'h10,
        OP_SRLI   = 8'h11, OP_SRA   = 8'h12, OP_SRAI   = 8'h13, OP_LUI    = 8'h14,
        OP_AUIPC  = 8'h15, OP_JAL   = 8'h16, OP_JALR   = 8'h17, OP_ADDW   = 8'h18,
        OP_ADDIW  = 8'h19, OP_SUBW  = 8'h1a, OP_SLLW   = 8'h1b, OP_SLLIW  = 8'h1c,
        OP_SRLW   = 8'h1d, OP_SRLIW = 8'h1e, OP_SRAW   = 8'h1f, OP_SRAIW  = 8'h20,
        // branches, decode assumes taken
        OP_BEQ    = 8'h28, OP_BNE   = 8'h29, OP_BLT    = 8'h2a, OP_BGE    = 8'h2b,
        OP_BLTU   = 8'h2c, OP_BGEU  = 8'h2d, OP_LOAD   = 8'h30, OP_STORE  = 8'h31,
        OP_MUL    = 8'h40, OP_MULH  = 8'h41, OP_MULHSU = 8'h42, OP_MULHU  = 8'h43,
        OP_MULW   = 8'h44, OP_DIV   = 8'h48, OP_DIVU   = 8'h49, OP_DIVW   = 8'h4a,
        OP_DIVUW  = 8'h4b, OP_REM   = 8'h4c, OP_REMU   = 8'h4d, OP_REMW   = 8'h4e,
        OP_REMUW  = 8'h4f, OP_ECALL = 8'h50, OP_EBREAK = 8'h51, OP_MRET   = 8'h52,
        OP_CSRRW  = 8'h53, OP_CSRRS = 8'h54, OP_CSRRC  = 8'h55, OP_CSRRWI = 8'h56,
        OP_CSRRSI = 8'h57, OP_CSRRCI = 8'h58
    } ex_opcode_e;

    function automatic logic [XLEN-1:0] sext_word(input logic [31:0] w);
        return {{(XLEN-32){w[31]}}, w};
    endfunction

endpackage

/* design/rv_csr_pkg.sv */
// machine CSR addresses, status bit positions and trap causes; import where CSRs are handled
package rv_csr_pkg;

    localparam int CSR_ADDR_W = 12;

    localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIE     = 12'h304;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC   = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC    = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE  = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIP     = 12'h344;

    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MIE_MTIE_BIT     = 7;
    localparam int MIP_MTIP_BIT     = 7;

    localparam logic [63:0] CAUSE_ECALL_M   = 64'd11;
    localparam logic [63:0] CAUSE_TIMER_INT = 64'h8000_0000_0000_0007;

endpackage

/* design/alu.sv */
// combinational integer ALU for all single-cycle opcodes; instantiated by the execute stage
`timescale 1ns/1ps

module alu import rv_exec_pkg::*; (
    input  logic [XLEN-1:0] op1_i,
    input  logic [XLEN-1:0] op2_i,
    input  ex_opcode_e      opcode_i,
    output logic [XLEN-1:0] alu_res_o
);

    logic [XLEN-1:0] sum, diff, sra, upper_imm;
    logic [31:0]     sllw, srlw, sraw;
    logic            lt_s, lt_u;

    assign sum  = op1_i + op2_i;
    assign diff = op1_i - op2_i;
    assign lt_s = $signed(op1_i) < $signed(op2_i);
    assign lt_u = op1_i < op2_i;
    assign sra  = $signed(op1_i) >>> op2_i[5:0];

    // op2 carries the raw 20-bit U immediate
    assign upper_imm = {{(XLEN-32){op2_i[19]}}, op2_i[19:0], 12'd0};

    // word shifts use a 5-bit amount
    assign sllw = op1_i[31:0] << op2_i[4:0];
    assign srlw = op1_i[31:0] >> op2_i[4:0];
    assign sraw = $signed(op1_i[31:0]) >>> op2_i[4:0];

    always_comb begin
        case (opcode_i)
            OP_ADD, OP_ADDI:     alu_res_o = sum;
            OP_SUB:              alu_res_o = diff;
            OP_SLT, OP_SLTI:     alu_res_o = {{(XLEN-1){1'b0}}, lt_s};
            OP_SLTU, OP_SLTIU:   alu_res_o = {{(XLEN-1){1'b0}}, lt_u};
            OP_XOR, OP_XORI:     alu_res_o = op1_i ^ op2_i;
            OP_OR, OP_ORI:       alu_res_o = op1_i | op2_i;
            OP_AND, OP_ANDI:     alu_res_o = op1_i & op2_i;
            OP_SLL, OP_SLLI:     alu_res_o = op1_i << op2_i[5:0];
            OP_SRL, OP_SRLI:     alu_res_o = op1_i >> op2_i[5:0];
            OP_SRA, OP_SRAI:     alu_res_o = sra;
            // op1 is zero for LUI and pc for AUIPC
            OP_LUI, OP_AUIPC:    alu_res_o = op1_i + upper_imm;
            // link address, op2 holds pc
            OP_JAL, OP_JALR:     alu_res_o = op2_i + 64'd4;
            OP_ADDW, OP_ADDIW:   alu_res_o = sext_word(sum[31:0]);
            OP_SUBW:             alu_res_o = sext_word(diff[31:0]);
            OP_SLLW, OP_SLLIW:   alu_res_o = sext_word(sllw);
            OP_SRLW, OP_SRLIW:   alu_res_o = sext_word(srlw);
            OP_SRAW, OP_SRAIW:   alu_res_o = sext_word(sraw);
            OP_EBREAK:           alu_res_o = op1_i;
            default:             alu_res_o = '0;
        endcase
    end

endmodule

/* design/multiplier.sv */
// iterative shift-add multiplier, 64 steps per product; started and held by the execute stage
`timescale 1ns/1ps

module multiplier import rv_exec_pkg::*; (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            start_i,
    input  ex_opcode_e      opcode_i,
    input  logic [XLEN-1:0] op1_i,
    input  logic [XLEN-1:0] op2_i,
    output logic [XLEN-1:0] product_o,
    output logic            finish_o
);

    typedef enum logic [1:0] {
        MUL_IDLE,
        MUL_BUSY,
        MUL_DONE
    } mul_state_e;

    mul_state_e        state_q;
    logic [5:0]        cnt_q;
    logic              load, op1_signed, op2_signed;
    logic [XLEN-1:0]   mag1, mag2, mplier_cur, mplier_q;
    logic [2*XLEN-1:0] acc_cur, acc_q, mcand_cur, mcand_q, prod;
    logic              neg_q;
    ex_opcode_e        op_q;

    assign load       = (state_q == MUL_IDLE) && start_i;
    assign op1_signed = (opcode_i == OP_MULH) || (opcode_i == OP_MULHSU);
    assign op2_signed = (opcode_i == OP_MULH);
    assign mag1       = (op1_signed && op1_i[XLEN-1]) ? -op1_i : op1_i;
    assign mag2       = (op2_signed && op2_i[XLEN-1]) ? -op2_i : op2_i;

    // first partial product is added in the load cycle
    assign acc_cur    = load ? '0 : acc_q;
    assign mcand_cur  = load ? {{XLEN{1'b0}}, mag1} : mcand_q;
    assign mplier_cur = load ? mag2 : mplier_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= MUL_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                MUL_IDLE: begin
                    if (start_i) begin
                        state_q <= MUL_BUSY;
                        cnt_q   <= 6'd1;
                    end
                end
                MUL_BUSY: begin
                    cnt_q <= cnt_q + 6'd1;
                    if (&cnt_q) begin
                        state_q <= MUL_DONE;
                    end
                end
                // start is ignored here so the held opcode does not restart
                default: state_q <= MUL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load || state_q == MUL_BUSY) begin
            acc_q    <= acc_cur + (mplier_cur[0] ? mcand_cur : '0);
            mcand_q  <= mcand_cur << 1;
            mplier_q <= mplier_cur >> 1;
        end
        if (load) begin
            op_q  <= opcode_i;
            neg_q <= (op1_signed && op1_i[XLEN-1]) ^ (op2_signed && op2_i[XLEN-1]);
        end
    end

    assign prod     = neg_q ? -acc_q : acc_q;
    assign finish_o = (state_q == MUL_DONE);

    always_comb begin
        case (op_q)
            OP_MUL:                       product_o = prod[XLEN-1:0];
            OP_MULW:                      product_o = sext_word(prod[31:0]);
            OP_MULH, OP_MULHSU, OP_MULHU: product_o = prod[2*XLEN-1:XLEN];
            default:                      product_o = '0;
        endcase
    end

endmodule

/* design/divider.sv */
// restoring divider for quotient and remainder opcodes; operands arrive width-adjusted from ex
`timescale 1ns/1ps

module divider import rv_exec_pkg::*; (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            start_i,
    input  ex_opcode_e      opcode_i,
    input  logic [XLEN-1:0] dividend_i,
    input  logic [XLEN-1:0] divisor_i,
    output logic [XLEN-1:0] result_o,
    output logic            finish_o
);

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_BUSY,
        DIV_DONE
    } div_state_e;

    div_state_e      state_q;
    logic [5:0]      cnt_q;
    logic            load, is_signed, neg_a, neg_b, qneg_q, rneg_q;
    logic [XLEN-1:0] mag_a, mag_b, rem_cur, quo_cur, dsor_cur;
    logic [XLEN-1:0] rem_q, quo_q, dsor_q, quo_fix, rem_fix;
    logic [XLEN:0]   shifted, trial;
    ex_opcode_e      op_q;

    assign load      = (state_q == DIV_IDLE) && start_i;
    assign is_signed = opcode_i inside {OP_DIV, OP_DIVW, OP_REM, OP_REMW};
    assign neg_a     = is_signed && dividend_i[XLEN-1];
    assign neg_b     = is_signed && divisor_i[XLEN-1];
    assign mag_a     = neg_a ? -dividend_i : dividend_i;
    assign mag_b     = neg_b ? -divisor_i : divisor_i;

    assign rem_cur  = load ? '0 : rem_q;
    assign quo_cur  = load ? mag_a : quo_q;
    assign dsor_cur = load ? mag_b : dsor_q;
    // shift in the next dividend bit, then try the subtraction
    assign shifted  = {rem_cur, quo_cur[XLEN-1]};
    assign trial    = shifted - {1'b0, dsor_cur};

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= DIV_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                DIV_IDLE: begin
                    if (start_i) begin
                        state_q <= DIV_BUSY;
                        cnt_q   <= 6'd1;
                    end
                end
                DIV_BUSY: begin
                    cnt_q <= cnt_q + 6'd1;
                    if (&cnt_q) begin
                        state_q <= DIV_DONE;
                    end
                end
                default: state_q <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load || state_q == DIV_BUSY) begin
            rem_q  <= trial[XLEN] ? shifted[XLEN-1:0] : trial[XLEN-1:0];
            quo_q  <= {quo_cur[XLEN-2:0], ~trial[XLEN]};
            dsor_q <= dsor_cur;
        end
        if (load) begin
            op_q   <= opcode_i;
            // x/0 keeps the all-ones quotient unsigned
            qneg_q <= (neg_a ^ neg_b) && (divisor_i != '0);
            rneg_q <= neg_a;
        end
    end

    assign quo_fix  = qneg_q ? -quo_q : quo_q;
    assign rem_fix  = rneg_q ? -rem_q : rem_q;
    assign finish_o = (state_q == DIV_DONE);

    always_comb begin
        case (op_q)
            OP_DIV, OP_DIVU:   result_o = quo_fix;
            OP_DIVW, OP_DIVUW: result_o = sext_word(quo_fix[31:0]);
            OP_REM, OP_REMU:   result_o = rem_fix;
            OP_REMW, OP_REMUW: result_o = sext_word(rem_fix[31:0]);
            default:           result_o = '0;
        endcase
    end

endmodule

/* design/csr.sv */
// machine CSR file with ECALL, MRET and timer trap entry; read and written by the execute stage
`timescale 1ns/1ps

module csr import rv_exec_pkg::*; import rv_csr_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic [XLEN-1:0]       pc_i,
    input  logic                  csr_wr_en_i,
    input  logic                  csr_rd_en_i,
    input  logic [CSR_ADDR_W-1:0] csr_idx_i,
    input  logic [XLEN-1:0]       wbck_csr_data_i,
    input  logic                  ecall_trap_ena_i,
    input  logic                  mret_ena_i,
    input  logic                  timer_intr_i,
    input  logic                  ex_stall_i,
    output logic [XLEN-1:0]       read_csr_data_o,
    output logic                  tmr_trap_ena_o
);

    logic [XLEN-1:0] mstatus, mie, mtvec, mepc, mcause, mip;
    logic            trap_ena;

    assign tmr_trap_ena_o = timer_intr_i & mie[MIE_MTIE_BIT] & mstatus[MSTATUS_MIE_BIT]
                            & ~ex_stall_i;
    assign trap_ena       = ecall_trap_ena_i | tmr_trap_ena_o;

    // trap and mret reads double as the redirect target
    always_comb begin
        read_csr_data_o = '0;
        if (trap_ena) begin
            read_csr_data_o = mtvec;
        end else if (mret_ena_i) begin
            read_csr_data_o = mepc;
        end else if (csr_rd_en_i) begin
            case (csr_idx_i)
                CSR_MSTATUS: read_csr_data_o = mstatus;
                CSR_MIE:     read_csr_data_o = mie;
                CSR_MTVEC:   read_csr_data_o = mtvec;
                CSR_MEPC:    read_csr_data_o = mepc;
                CSR_MCAUSE:  read_csr_data_o = mcause;
                CSR_MIP:     read_csr_data_o = mip;
                default:     read_csr_data_o = '0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mstatus <= '0;
            mie     <= '0;
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
            mip     <= '0;
        end else begin
            // pending bit follows the timer line
            mip[MIP_MTIP_BIT] <= timer_intr_i;
            if (!ex_stall_i) begin
                if (trap_ena) begin
                    mepc                      <= pc_i;
                    mcause                    <= ecall_trap_ena_i ? CAUSE_ECALL_M
                                                                  : CAUSE_TIMER_INT;
                    mstatus[MSTATUS_MPIE_BIT] <= mstatus[MSTATUS_MIE_BIT];
                    mstatus[MSTATUS_MIE_BIT]  <= 1'b0;
                end else if (mret_ena_i) begin
                    mstatus[MSTATUS_MIE_BIT]  <= mstatus[MSTATUS_MPIE_BIT];
                    mstatus[MSTATUS_MPIE_BIT] <= 1'b1;
                end else if (csr_wr_en_i) begin
                    case (csr_idx_i)
                        CSR_MSTATUS: mstatus <= wbck_csr_data_i;
                        CSR_MIE:     mie     <= wbck_csr_data_i;
                        CSR_MTVEC:   mtvec   <= wbck_csr_data_i;
                        CSR_MEPC:    mepc    <= wbck_csr_data_i;
                        CSR_MCAUSE:  mcause  <= wbck_csr_data_i;
                        // mip is set by hardware only
                        default: ;
                    endcase
                end
            end
        end
    end

endmodule

/* design/ex.sv */
// execute stage top: result select, branch resolve, CSR control and mul/div stall request
`timescale 1ns/1ps

module ex import rv_exec_pkg::*; import rv_csr_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic [XLEN-1:0]       pc_i,
    input  logic [ITYPE_W-1:0]    inst_type_i,
    input  ex_opcode_e            inst_opcode_i,
    input  logic [XLEN-1:0]       op1_i,
    input  logic [XLEN-1:0]       op2_i,
    input  logic                  rd_ena_i,
    input  logic [REG_ADDR_W-1:0] rd_addr_i,
    input  logic [LS_SEL_W-1:0]   ls_sel_i,
    input  logic [11:0]           addr_offset_i,
    input  logic                  timer_intr_i,
    input  logic                  ex_stall_i,
    output logic [ITYPE_W-1:0]    inst_type_o,
    output logic                  rd_ena_o,
    output logic [REG_ADDR_W-1:0] rd_addr_o,
    output logic [XLEN-1:0]       rd_data_o,
    output logic [LS_SEL_W-1:0]   ls_sel_o,
    output logic [XLEN-1:0]       ls_addr_o,
    output logic                  ex_flush_o,
    output logic                  branch_pc_ena_o,
    output logic [XLEN-1:0]       branch_pc_o,
    output logic                  ex_stall_req_o
);

    logic [XLEN-1:0]       alu_res, mul_res, div_res, dividend, divisor;
    logic [XLEN-1:0]       read_csr_data, wbck_csr_data;
    logic                  is_mul, is_div, div_word_s, div_word_u;
    logic                  mul_start, div_start, mul_finish, div_finish;
    logic                  csr_wr_en, csr_rd_en, ecall_trap_ena, mret_ena, tmr_trap_ena;
    logic                  branch_fail, trap_ena, csr_sel;
    logic [CSR_ADDR_W-1:0] csr_idx;

    alu u_alu (
        .op1_i     (op1_i),
        .op2_i     (op2_i),
        .opcode_i  (inst_opcode_i),
        .alu_res_o (alu_res)
    );

    assign is_mul    = inst_opcode_i inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU, OP_MULW};
    assign is_div    = inst_opcode_i inside {OP_DIV, OP_DIVU, OP_DIVW, OP_DIVUW,
                                             OP_REM, OP_REMU, OP_REMW, OP_REMUW};
    // start drops in the finish cycle, which also releases the stall
    assign mul_start = is_mul & ~mul_finish;
    assign div_start = is_div & ~div_finish;
    assign ex_stall_req_o = mul_start | div_start;

    multiplier u_mul (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .start_i   (mul_start),
        .opcode_i  (inst_opcode_i),
        .op1_i     (op1_i),
        .op2_i     (op2_i),
        .product_o (mul_res),
        .finish_o  (mul_finish)
    );

    // word division works on the low 32 bits
    assign div_word_s = inst_opcode_i inside {OP_DIVW, OP_REMW};
    assign div_word_u = inst_opcode_i inside {OP_DIVUW, OP_REMUW};
    assign dividend   = div_word_s ? sext_word(op1_i[31:0])
                      : div_word_u ? {{(XLEN-32){1'b0}}, op1_i[31:0]} : op1_i;
    assign divisor    = div_word_s ? sext_word(op2_i[31:0])
                      : div_word_u ? {{(XLEN-32){1'b0}}, op2_i[31:0]} : op2_i;

    divider u_div (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .start_i    (div_start),
        .opcode_i   (inst_opcode_i),
        .dividend_i (dividend),
        .divisor_i  (divisor),
        .result_o   (div_res),
        .finish_o   (div_finish)
    );

    // predicted taken, so redirect to pc+4 when the condition fails
    always_comb begin
        branch_fail = 1'b0;
        if (inst_type_i[ITYPE_BRANCH_BIT]) begin
            case (inst_opcode_i)
                OP_BEQ:  branch_fail = op1_i != op2_i;
                OP_BNE:  branch_fail = op1_i == op2_i;
                OP_BLT:  branch_fail = $signed(op1_i) >= $signed(op2_i);
                OP_BGE:  branch_fail = $signed(op1_i) < $signed(op2_i);
                OP_BLTU: branch_fail = op1_i >= op2_i;
                OP_BGEU: branch_fail = op1_i < op2_i;
                default: branch_fail = 1'b0;
            endcase
        end
    end

    assign trap_ena        = ecall_trap_ena | tmr_trap_ena;
    assign branch_pc_ena_o = branch_fail | trap_ena | mret_ena;
    assign branch_pc_o     = (trap_ena | mret_ena) ? read_csr_data
                           : branch_fail ? pc_i + 64'd4 : '0;
    assign ex_flush_o      = branch_pc_ena_o;

    // timer trap overrides whatever system opcode is present
    always_comb begin
        csr_wr_en      = 1'b0;
        csr_rd_en      = 1'b0;
        ecall_trap_ena = 1'b0;
        mret_ena       = 1'b0;
        if (inst_type_i[ITYPE_CSR_BIT] && !tmr_trap_ena) begin
            case (inst_opcode_i)
                OP_CSRRW, OP_CSRRWI: begin
                    csr_wr_en = 1'b1;
                    csr_rd_en = (rd_addr_i != '0);
                end
                OP_CSRRS, OP_CSRRSI, OP_CSRRC, OP_CSRRCI: begin
                    csr_wr_en = (op1_i != '0);
                    csr_rd_en = 1'b1;
                end
                OP_ECALL: ecall_trap_ena = 1'b1;
                OP_MRET:  mret_ena       = 1'b1;
                default:  csr_wr_en      = 1'b0;
            endcase
        end
    end

    assign csr_idx       = inst_type_i[ITYPE_CSR_BIT] ? op2_i[CSR_ADDR_W-1:0] : '0;
    assign wbck_csr_data = (inst_opcode_i inside {OP_CSRRS, OP_CSRRSI}) ? read_csr_data | op1_i
                         : (inst_opcode_i inside {OP_CSRRC, OP_CSRRCI}) ? read_csr_data & ~op1_i
                         : op1_i;

    csr u_csr (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .pc_i             (pc_i),
        .csr_wr_en_i      (csr_wr_en),
        .csr_rd_en_i      (csr_rd_en),
        .csr_idx_i        (csr_idx),
        .wbck_csr_data_i  (wbck_csr_data),
        .ecall_trap_ena_i (ecall_trap_ena),
        .mret_ena_i       (mret_ena),
        .timer_intr_i     (timer_intr_i),
        .ex_stall_i       (ex_stall_i),
        .read_csr_data_o  (read_csr_data),
        .tmr_trap_ena_o   (tmr_trap_ena)
    );

    assign csr_sel   = inst_type_i[ITYPE_CSR_BIT] && (inst_opcode_i != OP_EBREAK);
    assign rd_data_o = inst_type_i[ITYPE_STORE_BIT] ? op2_i
                     : csr_sel ? read_csr_data
                     : is_mul ? mul_res
                     : is_div ? div_res : alu_res;

    assign inst_type_o = inst_type_i & {ITYPE_W{~tmr_trap_ena}};
    assign rd_ena_o    = rd_ena_i & ~tmr_trap_ena;
    assign rd_addr_o   = rd_addr_i;
    assign ls_sel_o    = ls_sel_i;
    assign ls_addr_o   = (inst_type_i[ITYPE_LOAD_BIT] | inst_type_i[ITYPE_STORE_BIT])
                       ? op1_i + {{(XLEN-12){addr_offset_i[11]}}, addr_offset_i} : '0;

endmodule

/* bench/ex_tb.sv */
// testbench for the execute stage: replays the records of the stim file and checks every result
`timescale 1ns/1ps

module ex_tb import rv_exec_pkg::*; ();

    localparam int          CLK_PERIOD     = 8;
    localparam int          RESET_CYCLES   = 16;
    localparam int          N_REC          = 33;
    localparam int          REC_W          = 10;
    localparam int          CYCLES_PER_REC = 70;
    localparam logic [31:0] SEED           = 32'h8cd4_007d;

    logic                  clk;
    logic                  rst_n_i;
    logic [XLEN-1:0]       pc_i, op1_i, op2_i;
    logic [ITYPE_W-1:0]    inst_type_i;
    ex_opcode_e            inst_opcode_i;
    logic                  rd_ena_i;
    logic [REG_ADDR_W-1:0] rd_addr_i;
    logic [LS_SEL_W-1:0]   ls_sel_i;
    logic [11:0]           addr_offset_i;
    logic                  timer_intr_i, ex_stall_i;
    logic [ITYPE_W-1:0]    inst_type_o;
    logic                  rd_ena_o;
    logic [REG_ADDR_W-1:0] rd_addr_o;
    logic [XLEN-1:0]       rd_data_o, ls_addr_o, branch_pc_o;
    logic [LS_SEL_W-1:0]   ls_sel_o;
    logic                  ex_flush_o, branch_pc_ena_o, ex_stall_req_o;

    logic [63:0]           stim_mem [0:N_REC*REC_W-1];
    logic [31:0]           filler_a, filler_b;
    int                    data_errs, flag_errs;

    ex u_dut (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .pc_i            (pc_i),
        .inst_type_i     (inst_type_i),
        .inst_opcode_i   (inst_opcode_i),
        .op1_i           (op1_i),
        .op2_i           (op2_i),
        .rd_ena_i        (rd_ena_i),
        .rd_addr_i       (rd_addr_i),
        .ls_sel_i        (ls_sel_i),
        .addr_offset_i   (addr_offset_i),
        .timer_intr_i    (timer_intr_i),
        .ex_stall_i      (ex_stall_i),
        .inst_type_o     (inst_type_o),
        .rd_ena_o        (rd_ena_o),
        .rd_addr_o       (rd_addr_o),
        .rd_data_o       (rd_data_o),
        .ls_sel_o        (ls_sel_o),
        .ls_addr_o       (ls_addr_o),
        .ex_flush_o      (ex_flush_o),
        .branch_pc_ena_o (branch_pc_ena_o),
        .branch_pc_o     (branch_pc_o),
        .ex_stall_req_o  (ex_stall_req_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    initial begin
        #((N_REC * CYCLES_PER_REC + RESET_CYCLES) * CLK_PERIOD);
        $display("timeout: the stage did not get through the records in time");
        $display("tests failed");
        $finish;
    end

    task automatic check_data(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                              input string what);
        if (got !== exp) begin
            data_errs++;
            $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            flag_errs++;
            $display("ERROR %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic clear_inputs();
        inst_opcode_i = OP_NOP;
        inst_type_i   = '0;
        pc_i          = '0;
        op1_i         = '0;
        op2_i         = '0;
        rd_ena_i      = 1'b0;
        rd_addr_i     = '0;
        ls_sel_i      = '0;
        addr_offset_i = '0;
        timer_intr_i  = 1'b0;
        ex_stall_i    = 1'b0;
    endtask

    // one empty cycle so a finished unit falls back to idle
    task automatic drive_idle();
        @(negedge clk);
        clear_inputs();
    endtask

    task automatic run_record(input int idx);
        int                 base;
        logic [XLEN-1:0]    exp_data, exp_bpc, exp_addr;
        logic [ITYPE_W-1:0] exp_type;
        logic               exp_br, exp_rd_ena, muldiv, saw_stall;
        base = idx * REC_W;
        @(negedge clk);
        inst_opcode_i = ex_opcode_e'(stim_mem[base][7:0]);
        inst_type_i   = stim_mem[base+1][ITYPE_W-1:0];
        pc_i          = stim_mem[base+2];
        op1_i         = stim_mem[base+3];
        op2_i         = stim_mem[base+4];
        rd_addr_i     = stim_mem[base+5][REG_ADDR_W-1:0];
        rd_ena_i      = (stim_mem[base+5] != 64'd0);
        timer_intr_i  = stim_mem[base+6][0];
        ls_sel_i      = filler_a[LS_SEL_W-1:0];
        addr_offset_i = filler_b[11:0];
        exp_data      = stim_mem[base+7];
        exp_br        = stim_mem[base+8][0];
        exp_bpc       = stim_mem[base+9];
        // a taken timer trap kills the register write
        exp_rd_ena    = rd_ena_i && !timer_intr_i;
        exp_type      = timer_intr_i ? '0 : inst_type_i;
        // address only for loads and stores
        if (inst_type_i[ITYPE_LOAD_BIT] || inst_type_i[ITYPE_STORE_BIT]) begin
            exp_addr = op1_i + {{(XLEN-12){addr_offset_i[11]}}, addr_offset_i};
        end else begin
            exp_addr = '0;
        end
        muldiv        = inst_opcode_i inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU, OP_MULW,
                                              OP_DIV, OP_DIVU, OP_DIVW, OP_DIVUW,
                                              OP_REM, OP_REMU, OP_REMW, OP_REMUW};
        saw_stall     = 1'b0;
        // sample a quarter period after each edge
        #(CLK_PERIOD/4);
        while (ex_stall_req_o) begin
            saw_stall = 1'b1;
            @(posedge clk);
            #(CLK_PERIOD/4);
        end
        check_data(rd_data_o, exp_data, $sformatf("record %0d rd_data", idx));
        check_flag(branch_pc_ena_o, exp_br, $sformatf("record %0d branch_pc_ena", idx));
        if (exp_br) begin
            check_data(branch_pc_o, exp_bpc, $sformatf("record %0d branch_pc", idx));
        end
        check_flag(ex_flush_o, exp_br, $sformatf("record %0d ex_flush", idx));
        check_flag(rd_ena_o, exp_rd_ena, $sformatf("record %0d rd_ena", idx));
        check_flag(saw_stall, muldiv, $sformatf("record %0d stall seen", idx));
        check_data(XLEN'(inst_type_o), XLEN'(exp_type),
                   $sformatf("record %0d inst_type", idx));
        check_data(XLEN'(rd_addr_o), XLEN'(rd_addr_i), $sformatf("record %0d rd_addr", idx));
        check_data(XLEN'(ls_sel_o), XLEN'(ls_sel_i), $sformatf("record %0d ls_sel", idx));
        check_data(ls_addr_o, exp_addr, $sformatf("record %0d ls_addr", idx));
    endtask

    initial begin
        data_errs = 0;
        flag_errs = 0;
        clear_inputs();
        rst_n_i = 1'b0;
        void'($urandom(SEED));
        filler_a = $urandom();
        filler_b = $urandom();
        $readmemh("bench/ex_stim.txt", stim_mem);
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        for (int i = 0; i < N_REC; i++) begin
            run_record(i);
            drive_idle();
        end
        @(negedge clk);
        $display("checks done: %0d data errors, %0d flag errors", data_errs, flag_errs);
        if (data_errs == 0 && flag_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* bench/ex_stim.txt */
// opcode class pc op1 op2 rd timer, then expected rd_data branch_ena branch_pc
// class bits: 01 store, 02 load, 04 branch, 80 system
01 00 1000 7 5 1 0 c 0 0
04 00 1000 ffffffffffffffff 1 2 0 1 0 0
06 00 1000 ffffffffffffffff 1 3 0 0 0 0
12 00 1000 8000000000000000 4 4 0 f800000000000000 0 0
1f 00 1000 80000000 4 5 0 fffffffff8000000 0 0
18 00 1000 7fffffff 1 6 0 ffffffff80000000 0 0
40 00 1000 3 fffffffffffffffb 7 0 fffffffffffffff1 0 0
41 00 1000 8000000000000000 2 8 0 ffffffffffffffff 0 0
42 00 1000 ffffffffffffffff ffffffffffffffff 9 0 ffffffffffffffff 0 0
43 00 1000 ffffffffffffffff ffffffffffffffff a 0 fffffffffffffffe 0 0
44 00 1000 7fffffff 2 b 0 fffffffffffffffe 0 0
48 00 1000 fffffffffffffff9 2 c 0 fffffffffffffffd 0 0
4c 00 1000 fffffffffffffff9 2 d 0 ffffffffffffffff 0 0
49 00 1000 64 0 e 0 ffffffffffffffff 0 0
4d 00 1000 64 0 f 0 64 0 0
48 00 1000 8000000000000000 ffffffffffffffff 10 0 8000000000000000 0 0
4a 00 1000 80000000 ffffffff 11 0 ffffffff80000000 0 0
4f 00 1000 ffffffff00000007 100000003 12 0 1 0 0
28 04 2000 1 2 0 0 0 1 2004
29 04 2000 3 4 0 0 0 0 0
2a 04 2000 1 ffffffffffffffff 0 0 0 1 2004
2b 04 2000 1 ffffffffffffffff 0 0 0 0 0
2c 04 2000 1 ffffffffffffffff 0 0 0 0 0
2d 04 2000 1 ffffffffffffffff 0 0 0 1 2004
53 80 3000 80000100 305 0 0 0 0 0
54 80 3000 0 305 5 0 80000100 0 0
50 80 3000 0 0 0 0 80000100 1 80000100
54 80 3004 0 342 6 0 b 0 0
52 80 3008 0 0 0 0 3000 1 3000
54 80 300c 80 304 0 0 0 0 0
54 80 3010 8 300 0 0 80 0 0
01 00 4000 1 2 3 1 3 1 80000100
54 80 4004 0 342 7 0 8000000000000007 0 0

/* tb.f */
design/rv_exec_pkg.sv
design/rv_csr_pkg.sv
design/alu.sv
design/multiplier.sv
design/divider.sv
design/csr.sv
design/ex.sv
bench/ex_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f tb.f --top-module ex_tb -o ex_tb_sim \
    && ./obj_dir/ex_tb_sim > sim.log 2>&1 \
    || echo "build or simulation did not complete"
[ -f sim.log ] && cat sim.log
grep -q "all tests passed" sim.log 2>/dev/null && echo "PASS" \
    || { echo "FAIL"; exit 1; }
